// ==== common/tetris_pkg.sv ====
// Playfield constants
package tetris_pkg;
	localparam int WELL_COLS = 10;
	localparam int WELL_ROWS = 20; // bit 0 top row, bit 19 bottom row
	localparam int ROW_W = $clog2(WELL_ROWS);
	localparam int COL_W = $clog2(WELL_COLS);
	localparam int CELL_SHIFT = 4; // 16 pixel cells
	localparam int COORD_W = 12;
	localparam int CELL_W = COORD_W - CELL_SHIFT;
	localparam int NUM_SHAPES = 7;
	localparam int SHAPE_W = 3;
	localparam int GRAVITY_FRAMES = 8;
	localparam int GRAV_W = $clog2(GRAVITY_FRAMES);
	localparam int FLICK_STEPS = 4; // three toggles, then removal
	localparam int FLICK_W = $clog2(FLICK_STEPS);
	localparam int ACT_W = 3; // left, right, drop

	// each entry lists column 9 first, down to column 0
	localparam logic [NUM_SHAPES-1:0][WELL_COLS-1:0][WELL_ROWS-1:0] SPAWN_SHAPES = '{
		'{20'h0, 20'h0, 20'h0, 20'h1, 20'h1, 20'h1, 20'h1, 20'h0, 20'h0, 20'h0}, // straight
		'{20'h0, 20'h0, 20'h0, 20'h2, 20'h3, 20'h2, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h1, 20'h3, 20'h2, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h2, 20'h3, 20'h1, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h2, 20'h2, 20'h3, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h3, 20'h2, 20'h2, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h0, 20'h3, 20'h3, 20'h0, 20'h0, 20'h0, 20'h0}  // square
	};
endpackage

// ==== common/piece_if.sv ====
// Piece to board link
`timescale 1ns/1ps

interface piece_if;
	import tetris_pkg::*;

	logic [WELL_COLS-1:0][WELL_ROWS-1:0] cells; // falling piece, column words
	logic valid; // piece is live
	logic land;
	logic merged; // single credit comes back

	modport piece (
		output cells,
		output valid,
		input land,
		input merged
	);

	modport board (
		input cells,
		input valid,
		output land,
		output merged
	);
endinterface

// ==== piece/piece_unit.sv ====
// Falling piece control
`timescale 1ns/1ps

module piece_unit (
	input logic clk,
	input logic rst,
	input logic frame,
	input logic [tetris_pkg::ACT_W-1:0] action,
	piece_if.piece pif
);
	import tetris_pkg::*;

	logic [GRAV_W-1:0] frame_cnt;
	logic [SHAPE_W-1:0] shape;
	logic credit; // one spawn allowed per merge
	logic valid;
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] cells;
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] side;
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] moved;
	logic tick;
	logic go_left;
	logic go_right;
	logic go_drop;
	logic go_down;

	assign tick = frame && (frame_cnt == '0);

	// left beats right beats drop, walls refuse a side step
	assign go_left = action[2] && (cells[0] == '0);
	assign go_right = !action[2] && action[1] && (cells[WELL_COLS-1] == '0);
	assign go_drop = !action[2] && !action[1] && action[0];
	assign go_down = tick || go_drop; // never more than one row

	always_comb begin
		if (go_left)
			side = cells >> WELL_ROWS;
		else if (go_right)
			side = cells << WELL_ROWS;
		else
			side = cells;
		for (int c = 0; c < WELL_COLS; c++) begin
			moved[c] = go_down ? (side[c] << 1) : side[c];
		end
	end

	// gravity divider
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_cnt <= '0;
		end else if (frame) begin
			if (frame_cnt == GRAV_W'(GRAVITY_FRAMES - 1))
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credit <= 1'b1;
			valid <= 1'b0;
			shape <= '0;
			cells <= '0;
		end else if (pif.merged) begin
			credit <= 1'b1; // piece now lives in the well
			valid <= 1'b0;
			cells <= '0;
		end else if (frame) begin
			if (tick && credit) begin
				cells <= SPAWN_SHAPES[shape];
				valid <= 1'b1;
				credit <= 1'b0;
				if (shape == SHAPE_W'(NUM_SHAPES - 1))
					shape <= '0;
				else
					shape <= shape + 1'b1;
			end else if (valid && !pif.land) begin
				cells <= moved; // frozen while landed
			end
		end
	end

	assign pif.cells = cells;
	assign pif.valid = valid;
endmodule

// ==== board/board_unit.sv ====
// Well storage and merge
`timescale 1ns/1ps

module board_unit (
	input logic clk,
	input logic rst,
	piece_if.board pif,
	input logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] clear_well,
	input logic clear_we,
	output logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] well
);
	import tetris_pkg::*;

	logic [WELL_COLS-1:0] col_hit;
	logic land;
	logic merged;

	// piece on the floor or resting on a settled cell
	always_comb begin
		for (int c = 0; c < WELL_COLS; c++) begin
			col_hit[c] = pif.cells[c][WELL_ROWS-1] ||
				((pif.cells[c] << 1) & well[c]) != '0;
		end
	end

	assign land = |col_hit;
	assign merged = pif.valid && land;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			well <= '0;
		end else if (merged) begin
			well <= well | pif.cells; // merge wins over a clear write
		end else if (clear_we) begin
			well <= clear_well;
		end
	end

	assign pif.land = land;
	assign pif.merged = merged;
endmodule

// ==== board/line_clear.sv ====
// Full row flicker and removal
`timescale 1ns/1ps

module line_clear (
	input logic clk,
	input logic rst,
	input logic frame,
	input logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] well,
	output logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] clear_well,
	output logic clear_we
);
	import tetris_pkg::*;

	logic [WELL_ROWS-1:0] flick_mask; // holds the row while it is toggled off
	logic [FLICK_W-1:0] step;
	logic [WELL_ROWS-1:0] full;
	logic [WELL_ROWS-1:0] keep;
	logic [ROW_W-1:0] sel;
	logic found;
	logic last_step;

	always_comb begin
		full = '1;
		for (int c = 0; c < WELL_COLS; c++) begin
			full = full & well[c]; // set in every column
		end
		full = full | flick_mask;
		found = 1'b0;
		sel = '0;
		for (int r = 0; r < WELL_ROWS; r++) begin
			if (full[r]) begin
				found = 1'b1;
				sel = ROW_W'(r); // bottom-most wins
			end
		end
		for (int r = 0; r < WELL_ROWS; r++) begin
			keep[r] = (r > sel); // rows below the cleared one stay
		end
	end

	assign last_step = (step == FLICK_W'(FLICK_STEPS - 1));

	always_comb begin
		for (int c = 0; c < WELL_COLS; c++) begin
			if (last_step)
				clear_well[c] = (well[c] & keep) | ((well[c] << 1) & ~keep);
			else
				clear_well[c] = well[c] ^ (WELL_ROWS'(1) << sel);
		end
	end

	assign clear_we = frame && found;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			step <= '0;
			flick_mask <= '0;
		end else if (clear_we) begin
			if (last_step) begin
				step <= '0;
				flick_mask <= '0;
			end else begin
				step <= step + 1'b1;
				flick_mask <= WELL_ROWS'(1) << sel;
			end
		end
	end
endmodule

// ==== verilog/cell_scan.sv ====
// Raster pixel readout
`timescale 1ns/1ps

module cell_scan (
	input logic clk,
	input logic rst,
	input logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] well,
	input logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] piece,
	input logic [tetris_pkg::COORD_W-1:0] x,
	input logic [tetris_pkg::COORD_W-1:0] y,
	input logic line_start,
	output logic lit
);
	import tetris_pkg::*;

	logic [CELL_W-1:0] x_cell;
	logic [CELL_W-1:0] y_cell;
	logic [COL_W-1:0] col_sel;
	logic [ROW_W-1:0] row_sel;
	logic [WELL_ROWS-1:0] row_buf; // one well column per scan line

	assign x_cell = x[COORD_W-1:CELL_SHIFT];
	assign y_cell = y[COORD_W-1:CELL_SHIFT];
	assign col_sel = COL_W'(y_cell - 1'b1); // y cell 1 is column 0
	assign row_sel = ROW_W'(WELL_ROWS - 1) - ROW_W'(x_cell); // bottom row on the left

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row_buf <= '0;
			lit <= 1'b0;
		end else begin
			if (line_start) begin
				if (y_cell >= CELL_W'(1) && y_cell <= CELL_W'(WELL_COLS))
					row_buf <= well[col_sel] | piece[col_sel];
				else
					row_buf <= '0;
			end
			lit <= (x_cell < CELL_W'(WELL_ROWS)) && row_buf[row_sel];
		end
	end
endmodule

// ==== verilog/tetris_top.sv ====
// Playfield core top
`timescale 1ns/1ps

module tetris_top (
	input logic clk,
	input logic rst,
	input logic frame,
	input logic [tetris_pkg::ACT_W-1:0] action,
	input logic [tetris_pkg::COORD_W-1:0] x,
	input logic [tetris_pkg::COORD_W-1:0] y,
	input logic line_start,
	output logic lit
);
	import tetris_pkg::*;

	logic [WELL_COLS-1:0][WELL_ROWS-1:0] well;
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] clear_well;
	logic clear_we;

	piece_if pif ();

	piece_unit piece_unit_i (
		.clk(clk),
		.rst(rst),
		.frame(frame),
		.action(action),
		.pif(pif.piece)
	);

	board_unit board_unit_i (
		.clk(clk),
		.rst(rst),
		.pif(pif.board),
		.clear_well(clear_well),
		.clear_we(clear_we),
		.well(well)
	);

	line_clear line_clear_i (
		.clk(clk),
		.rst(rst),
		.frame(frame),
		.well(well),
		.clear_well(clear_well),
		.clear_we(clear_we)
	);

	cell_scan cell_scan_i (
		.clk(clk),
		.rst(rst),
		.well(well),
		.piece(pif.cells),
		.x(x),
		.y(y),
		.line_start(line_start),
		.lit(lit)
	);
endmodule

// ==== testbench/tetris_assert.sv ====
// Board unit checks
`timescale 1ns/1ps

module tetris_assert (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic land,
	input logic merged,
	input logic [tetris_pkg::WELL_COLS-1:0][tetris_pkg::WELL_ROWS-1:0] cells
);
	// every shape has four cells, no move may lose one
	piece_intact: assert property (@(posedge clk) disable iff (rst)
		valid |-> ($countones(cells) == 4))
		else $error("live piece does not have four cells");

	no_idle_land: assert property (@(posedge clk) disable iff (rst)
		!valid |-> !land)
		else $error("land raised without a live piece");

	single_merge: assert property (@(posedge clk) disable iff (rst)
		merged |=> !merged)
		else $error("merged on two cycles in a row");
endmodule

bind board_unit tetris_assert tetris_assert_i (
	.clk(clk),
	.rst(rst),
	.valid(pif.valid),
	.land(land),
	.merged(merged),
	.cells(pif.cells)
);

// ==== testbench/tetris_tb.sv ====
// Playfield core testbench
`timescale 1ns/1ps

module tetris_tb;
	import tetris_pkg::*;

	localparam int NUM_FRAMES = 240;
	localparam int GRAVITY_ONLY = 24; // frames with no keys pressed
	localparam int FILL_END = 128; // random keys from here on
	localparam int SCAN_Y = WELL_COLS + 2; // one dark cell on each side
	localparam int SCAN_X = WELL_ROWS + 1;
	localparam int FRAME_CYCLES = 6 + SCAN_Y * (SCAN_X + 2); // frame, settle and one sweep
	localparam longint WATCHDOG_NS = longint'(NUM_FRAMES + 2) * FRAME_CYCLES * 10 + 20000;

	logic clk;
	logic rst;
	logic frame;
	logic [ACT_W-1:0] action;
	logic [COORD_W-1:0] x;
	logic [COORD_W-1:0] y;
	logic line_start;
	logic lit;

	// reference model state
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] m_well;
	logic [WELL_COLS-1:0][WELL_ROWS-1:0] m_piece;
	logic [WELL_ROWS-1:0] m_flick;
	logic m_valid;
	logic m_credit;
	int m_shape;
	int m_cnt;
	int m_step;

	int rows_removed;
	int refusals;
	event scan_req;
	event scan_done;

	tetris_top tetris_top_i (
		.clk(clk),
		.rst(rst),
		.frame(frame),
		.action(action),
		.x(x),
		.y(y),
		.line_start(line_start),
		.lit(lit)
	);

	always #5 clk = ~clk;

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_lit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_row(input string name, input logic [WELL_ROWS-1:0] got,
			input logic [WELL_ROWS-1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// square, L, J and S fill the bottom row from left to right
	function automatic logic [ACT_W-1:0] pick_action(input int f);
		int target;
		int lo;
		int bot;
		if (f >= FILL_END)
			return ACT_W'($urandom % 8);
		if (f < GRAVITY_ONLY || !m_valid)
			return '0;
		case ((m_shape + NUM_SHAPES - 1) % NUM_SHAPES)
			0: target = 0;
			1: target = 2;
			2: target = 5;
			3: target = 7;
			default: target = -1;
		endcase
		if (target < 0)
			return '0;
		lo = WELL_COLS;
		bot = 0;
		for (int c = WELL_COLS - 1; c >= 0; c--)
			if (m_piece[c] != '0)
				lo = c;
		for (int c = 0; c < WELL_COLS; c++)
			for (int r = 0; r < WELL_ROWS; r++)
				if (m_piece[c][r] && r > bot)
					bot = r;
		if (lo > target)
			return 3'b100;
		if (lo < target)
			return 3'b010;
		if (target == 0 && bot < 5)
			return 3'b100; // lean on the left wall
		return 3'b001;
	endfunction

	// one frame of the game: clear step, piece move, then landing
	function automatic void advance_model(input logic [ACT_W-1:0] act);
		logic [WELL_COLS-1:0][WELL_ROWS-1:0] nxt_well;
		logic [WELL_COLS-1:0][WELL_ROWS-1:0] pos;
		logic row_full;
		logic tick;
		logic hit;
		int sel;
		nxt_well = m_well;
		sel = -1;
		for (int r = 0; r < WELL_ROWS; r++) begin
			row_full = 1'b1;
			for (int c = 0; c < WELL_COLS; c++)
				if (!m_well[c][r])
					row_full = 1'b0;
			if (row_full || m_flick[r])
				sel = r; // bottom-most
		end
		if (sel >= 0) begin
			if (m_step == FLICK_STEPS - 1) begin
				for (int c = 0; c < WELL_COLS; c++)
					for (int r = 0; r <= sel; r++)
						nxt_well[c][r] = (r == 0) ? 1'b0 : m_well[c][r-1];
				m_step = 0;
				m_flick = '0;
				rows_removed++;
			end else begin
				for (int c = 0; c < WELL_COLS; c++)
					nxt_well[c][sel] = ~m_well[c][sel];
				m_step++;
				m_flick = '0;
				m_flick[sel] = 1'b1;
			end
		end
		tick = (m_cnt == 0);
		m_cnt = (m_cnt + 1) % GRAVITY_FRAMES;
		if (tick && m_credit) begin
			m_piece = SPAWN_SHAPES[m_shape];
			m_valid = 1'b1;
			m_credit = 1'b0;
			m_shape = (m_shape + 1) % NUM_SHAPES;
		end else if (m_valid) begin
			pos = m_piece;
			if (act[2]) begin
				if (m_piece[0] == '0) begin
					for (int c = 0; c < WELL_COLS - 1; c++)
						pos[c] = m_piece[c+1];
					pos[WELL_COLS-1] = '0;
				end else begin
					refusals++; // left wall
				end
			end else if (act[1]) begin
				if (m_piece[WELL_COLS-1] == '0) begin
					for (int c = 1; c < WELL_COLS; c++)
						pos[c] = m_piece[c-1];
					pos[0] = '0;
				end else begin
					refusals++; // right wall
				end
			end
			if (tick || (act[0] && !act[2] && !act[1]))
				for (int c = 0; c < WELL_COLS; c++)
					pos[c] = {pos[c][WELL_ROWS-2:0], 1'b0}; // one row down
			m_piece = pos;
		end
		m_well = nxt_well;
		hit = 1'b0;
		for (int c = 0; c < WELL_COLS; c++) begin
			if (m_piece[c][WELL_ROWS-1])
				hit = 1'b1;
			for (int r = 0; r < WELL_ROWS - 1; r++)
				if (m_piece[c][r] && m_well[c][r+1])
					hit = 1'b1;
		end
		if (m_valid && hit) begin
			m_well = m_well | m_piece;
			m_piece = '0;
			m_valid = 1'b0;
			m_credit = 1'b1;
		end
	endfunction

	// compare process: sweeps the screen each time it is asked
	initial begin
		logic [WELL_ROWS-1:0] seen;
		logic [WELL_ROWS-1:0] exp;
		forever begin
			@(scan_req);
			for (int yc = 0; yc < SCAN_Y; yc++) begin
				@(negedge clk);
				y = COORD_W'(yc << CELL_SHIFT);
				x = '0;
				line_start = 1'b1;
				@(negedge clk);
				line_start = 1'b0;
				seen = '0;
				exp = '0;
				if (yc >= 1 && yc <= WELL_COLS)
					exp = m_well[yc-1] | m_piece[yc-1];
				for (int xc = 0; xc < SCAN_X; xc++) begin
					x = COORD_W'(xc << CELL_SHIFT);
					@(negedge clk);
					if (xc < WELL_ROWS)
						seen[WELL_ROWS-1-xc] = lit;
					else
						check_lit($sformatf("lit beyond bottom, y cell %0d", yc), lit, 1'b0);
				end
				check_row($sformatf("lit row for y cell %0d", yc), seen, exp);
			end
			->scan_done;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		stop_run();
	end

	initial begin
		logic [ACT_W-1:0] act;
		void'($urandom(34));
		clk = 1'b0;
		rst = 1'b1;
		frame = 1'b0;
		action = '0;
		x = '0;
		y = '0;
		line_start = 1'b0;
		rows_removed = 0;
		refusals = 0;
		m_well = '0;
		m_piece = '0;
		m_flick = '0;
		m_valid = 1'b0;
		m_credit = 1'b1;
		m_shape = 0;
		m_cnt = 0;
		m_step = 0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		->scan_req; // all dark before the first tick
		@(scan_done);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			act = pick_action(f);
			@(negedge clk);
			frame = 1'b1;
			action = act;
			@(negedge clk);
			frame = 1'b0;
			advance_model(act);
			repeat (4) @(negedge clk);
			->scan_req;
			@(scan_done);
		end
		if (rows_removed > 0 && refusals > 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("the run removed no full row or refused no side move at a wall");
			stop_run();
		end
	end
endmodule

// ==== files.f ====
common/tetris_pkg.sv
common/piece_if.sv
piece/piece_unit.sv
board/board_unit.sv
board/line_clear.sv
verilog/cell_scan.sv
verilog/tetris_top.sv
testbench/tetris_assert.sv
testbench/tetris_tb.sv

// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: run clean

obj_dir/Vtetris_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tetris_tb

run: obj_dir/Vtetris_tb
	./obj_dir/Vtetris_tb | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
